/* vlog.f */
rtl/talker_pkg.sv
rtl/flash_bus_if.sv
rtl/play_req_if.sv
rtl/flash_arbiter.sv
rtl/phoneme_lookup.sv
rtl/sample_fetcher.sv
rtl/talker_top.sv
testbench/tb_clock_gen.sv
testbench/talker_chk.sv
testbench/tb_talker_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass message in the output
cd "$(dirname "$0")" || exit 1
sim_out=""
verilator --binary --assert --top-module tb_talker_top -f vlog.f \
  && sim_out="$(./obj_dir/Vtb_talker_top 2>&1)"
printf '%s\n' "${sim_out}"
printf '%s\n' "${sim_out}" | grep -qF "All tests passed!" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

/* testbench/tb_talker_top.sv */
`timescale 1ns/100ps

module tb_talker_top;

  localparam logic [31:0] SEED = 32'hfae4_7f31;
  localparam int PAUSE_AT = 24;
  localparam int PAUSE_CYCLES = 300;

  logic CLK_50M;
  logic rst = 1'b1;
  logic [talker_pkg::PHONEME_W-1:0] phoneme_code = '0;
  logic phoneme_start = 1'b0;
  logic phoneme_busy;
  logic idle;
  logic flash_read;
  logic [talker_pkg::FLASH_ADDR_W-1:0] flash_addr;
  logic flash_wait = 1'b0;
  logic [31:0] flash_rdata = '0;
  logic flash_rdata_valid = 1'b0;
  logic [talker_pkg::SAMPLE_W-1:0] sample_data;
  logic sample_valid;
  logic credit_return = 1'b0;

  // Flash image and the expected sample stream
  logic [31:0] flash_mem [0:65535];
  logic [7:0] expected [$];
  logic [31:0] fill_rng = SEED;
  logic [31:0] flash_rng = SEED ^ 32'h0f0f_5a5a;
  logic [31:0] sink_rng = SEED ^ 32'h3c3c_a5a5;
  int rd_idx = 0;
  int sb_errors = 0;
  int seq_errors = 0;
  int chk_errors = 0;
  int cycle_count = 0;
  int timeout_limit = 100000;
  // Flash model state
  logic pending = 1'b0;
  logic [2:0] lat = '0;
  logic [15:0] paddr = '0;
  // Credit sink state
  logic [2:0] gap = '0;
  int owed = 0;
  int seen = 0;
  int pause_left = 0;

  tb_clock_gen #(.PERIOD_NS(20)) i_clock (.CLK_50M(CLK_50M));

  talker_top #(.CREDITS(talker_pkg::DEFAULT_CREDITS)) i_dut
  (
    .CLK_50M           (CLK_50M),
    .rst               (rst),
    .phoneme_code      (phoneme_code),
    .phoneme_start     (phoneme_start),
    .phoneme_busy      (phoneme_busy),
    .idle              (idle),
    .flash_read        (flash_read),
    .flash_addr        (flash_addr),
    .flash_wait        (flash_wait),
    .flash_rdata       (flash_rdata),
    .flash_rdata_valid (flash_rdata_valid),
    .sample_data       (sample_data),
    .sample_valid      (sample_valid),
    .credit_return     (credit_return)
  );

  bind talker_top talker_chk #(.CREDITS(CREDITS)) i_chk
  (
    .CLK_50M           (CLK_50M),
    .rst               (rst),
    .flash_read        (flash_read),
    .flash_addr        (flash_addr),
    .flash_wait        (flash_wait),
    .flash_rdata_valid (flash_rdata_valid),
    .sample_valid      (sample_valid),
    .credit_return     (credit_return),
    .phoneme_busy      (phoneme_busy),
    .idle              (idle)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Table entry with the start word in the low half and the end word in the high half
  task automatic write_entry(input logic [5:0] code, input logic [15:0] first,
                             input logic [15:0] last);
    flash_mem[talker_pkg::TABLE_BASE + 16'(code)] = {last, first};
  endtask

  function automatic int sample_count(input logic [5:0] code);
    logic [31:0] entry;
    entry = flash_mem[talker_pkg::TABLE_BASE + 16'(code)];
    if (entry[31:16] < entry[15:0])
      return 0;
    return 4 * (int'(entry[31:16]) - int'(entry[15:0]) + 1);
  endfunction

  // Issue one code once the slot is free, and queue its bytes
  task automatic play_phoneme(input logic [5:0] code);
    logic [31:0] entry;
    int first_w;
    int last_w;
    do
      @(posedge CLK_50M);
    while (phoneme_busy);
    phoneme_code <= code;
    phoneme_start <= 1'b1;
    entry = flash_mem[talker_pkg::TABLE_BASE + 16'(code)];
    first_w = int'(entry[15:0]);
    last_w = int'(entry[31:16]);
    for (int w = first_w; w <= last_w; w++)
      for (int b = 0; b < 4; b++)
        expected.push_back(8'(flash_mem[16'(w)] >> (8 * b)));
    @(posedge CLK_50M);
    phoneme_start <= 1'b0;
  endtask

  task automatic wait_idle;
    do
      @(posedge CLK_50M);
    while (!idle);
    assert (rd_idx == expected.size())
      else
      begin
        seq_errors++;
        $display("Idle rose with %0d samples still missing", expected.size() - rd_idx);
      end
  endtask

  // ======================================================================
  // Flash model with random stalls and read latency
  // ======================================================================

  always @(posedge CLK_50M)
  begin
    flash_rdata_valid <= 1'b0;
    flash_rng = xorshift32(flash_rng);
    if (rst)
      pending = 1'b0;
    else
    begin
      flash_wait <= (flash_rng[3:2] == 2'b00);
      if (pending && lat == 3'd0)
      begin
        flash_rdata <= flash_mem[paddr];
        flash_rdata_valid <= 1'b1;
        pending = 1'b0;
      end
      else if (pending)
        lat = lat - 3'd1;
      else if (flash_read && !flash_wait)
      begin
        pending = 1'b1;
        paddr = flash_addr;
        lat = flash_rng[6:4];
      end
    end
  end

  // Credit sink with random gaps and one long pause
  always @(posedge CLK_50M)
  begin
    credit_return <= 1'b0;
    sink_rng = xorshift32(sink_rng);
    if (!rst)
    begin
      if (sample_valid)
      begin
        owed++;
        seen++;
        if (seen == PAUSE_AT)
          pause_left = PAUSE_CYCLES;
      end
      if (pause_left != 0)
        pause_left--;
      else if (gap != 3'd0)
        gap = gap - 3'd1;
      else if (owed != 0)
      begin
        credit_return <= 1'b1;
        owed--;
        gap = sink_rng[2:0];
      end
    end
  end

  // Scoreboard
  always @(posedge CLK_50M)
  begin
    if (!rst && sample_valid)
    begin
      assert (rd_idx < expected.size())
        else
        begin
          sb_errors++;
          $display("Sample sent when no sample was expected");
        end
      if (rd_idx < expected.size())
      begin
        assert (sample_data == expected[rd_idx])
          else
          begin
            sb_errors++;
            $display("FAIL sample_data = 0x%h, expected 0x%h", sample_data, expected[rd_idx]);
          end
        rd_idx++;
      end
    end
  end

  always @(posedge CLK_50M)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit)
    begin
      $display("Timeout, the DUT did not finish within %0d cycles", timeout_limit);
      $display("Test failures found");
      $finish;
    end
  end

  // ======================================================================
  // Test sequence
  // ======================================================================

  initial
  begin
    for (int i = 0; i < 65536; i++)
    begin
      fill_rng = xorshift32(fill_rng);
      flash_mem[16'(i)] = fill_rng ^ 32'(i);
    end
    write_entry(6'd5, 16'd100, 16'd103);
    write_entry(6'd12, 16'd200, 16'd209);
    write_entry(6'd7, 16'd400, 16'd400);
    // Silent phoneme, end below start
    write_entry(6'd33, 16'd300, 16'd299);
    timeout_limit = 40 * (sample_count(6'd5) + sample_count(6'd12) + sample_count(6'd7)
                          + sample_count(6'd33)) + 2000;
    repeat (10) @(posedge CLK_50M);
    rst <= 1'b0;
    play_phoneme(6'd5);
    wait_idle();
    // Second code queued while the first still plays
    play_phoneme(6'd12);
    play_phoneme(6'd7);
    wait_idle();
    play_phoneme(6'd33);
    wait_idle();
    repeat (5) @(posedge CLK_50M);
    chk_errors = i_dut.i_chk.fail_count;
    $display("Errors: scoreboard %0d, sequence %0d, assertions %0d",
             sb_errors, seq_errors, chk_errors);
    if (sb_errors == 0 && seq_errors == 0 && chk_errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

/* testbench/talker_chk.sv */
`timescale 1ns/100ps

module talker_chk
#(
  parameter int CREDITS = talker_pkg::DEFAULT_CREDITS
)
(
  input logic CLK_50M,
  input logic rst,
  input logic flash_read,
  input logic [talker_pkg::FLASH_ADDR_W-1:0] flash_addr,
  input logic flash_wait,
  input logic flash_rdata_valid,
  input logic sample_valid,
  input logic credit_return,
  input logic phoneme_busy,
  input logic idle
);

  // Samples sent and not yet paid back by the sink
  int in_flight;
  // Flash read accepted with its data not back yet
  logic read_open;
  int fail_count = 0;

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      in_flight <= 0;
      read_open <= 1'b0;
    end
    else
    begin
      in_flight <= in_flight + int'(sample_valid) - int'(credit_return);
      if (flash_read && !flash_wait)
        read_open <= 1'b1;
      else if (flash_rdata_valid)
        read_open <= 1'b0;
    end
  end

  // ======================================================================
  // Properties
  // ======================================================================

  a_reset_state: assert property (@(posedge CLK_50M)
    $past(rst) |-> (!flash_read && !sample_valid && !phoneme_busy && idle))
    else
    begin
      fail_count++;
      $error("Outputs not in their reset state");
    end

  a_wait_hold: assert property (@(posedge CLK_50M) disable iff (rst)
    (flash_read && flash_wait) |=> (flash_read && $stable(flash_addr)))
    else
    begin
      fail_count++;
      $error("Flash read or address changed during wait");
    end

  a_one_read: assert property (@(posedge CLK_50M) disable iff (rst)
    read_open |-> !flash_read)
    else
    begin
      fail_count++;
      $error("New flash read before data returned");
    end

  // Also catches samples sent during a credit pause
  a_credit_limit: assert property (@(posedge CLK_50M) disable iff (rst)
    sample_valid |-> (in_flight < CREDITS))
    else
    begin
      fail_count++;
      $error("Sample sent with no credit left");
    end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen
#(
  parameter int PERIOD_NS = 20
)
(
  output logic CLK_50M
);

  initial
    CLK_50M = 1'b0;

  always
    #(PERIOD_NS / 2) CLK_50M = ~CLK_50M;

endmodule

/* rtl/talker_top.sv */
`timescale 1ns/100ps

module talker_top
#(
  parameter int CREDITS = talker_pkg::DEFAULT_CREDITS
)
(
  input  logic CLK_50M,
  input  logic rst,

  // Phoneme command
  input  logic [talker_pkg::PHONEME_W-1:0] phoneme_code,
  input  logic phoneme_start,
  output logic phoneme_busy,
  output logic idle,

  // Flash read port
  output logic flash_read,
  output logic [talker_pkg::FLASH_ADDR_W-1:0] flash_addr,
  input  logic flash_wait,
  input  logic [talker_pkg::FLASH_DATA_W-1:0] flash_rdata,
  input  logic flash_rdata_valid,

  // Samples to the audio sink
  output logic [talker_pkg::SAMPLE_W-1:0] sample_data,
  output logic sample_valid,
  input  logic credit_return
);

  logic playing;

  flash_bus_if lookup_bus ();
  flash_bus_if fetch_bus ();
  play_req_if play_link ();

  flash_arbiter i_arbiter
  (
    .CLK_50M           (CLK_50M),
    .rst               (rst),
    .lookup_bus        (lookup_bus.arbiter),
    .fetch_bus         (fetch_bus.arbiter),
    .flash_read        (flash_read),
    .flash_addr        (flash_addr),
    .flash_wait        (flash_wait),
    .flash_rdata       (flash_rdata),
    .flash_rdata_valid (flash_rdata_valid)
  );

  phoneme_lookup i_lookup
  (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .phoneme_code  (phoneme_code),
    .phoneme_start (phoneme_start),
    .phoneme_busy  (phoneme_busy),
    .bus           (lookup_bus.requester),
    .play          (play_link.source)
  );

  sample_fetcher #(.CREDITS(CREDITS)) i_fetcher
  (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .play          (play_link.sink),
    .bus           (fetch_bus.requester),
    .sample_data   (sample_data),
    .sample_valid  (sample_valid),
    .credit_return (credit_return),
    .playing       (playing)
  );

  // Nothing queued, looked up or playing
  assign idle = !phoneme_busy && !play_link.valid && !playing;

endmodule

/* rtl/sample_fetcher.sv */
`timescale 1ns/100ps

module sample_fetcher
#(
  parameter int CREDITS = talker_pkg::DEFAULT_CREDITS
)
(
  input  logic CLK_50M,
  input  logic rst,
  play_req_if.sink play,
  flash_bus_if.requester bus,
  output logic [talker_pkg::SAMPLE_W-1:0] sample_data,
  output logic sample_valid,
  input  logic credit_return,
  output logic playing
);

  localparam int AW = talker_pkg::FLASH_ADDR_W;
  localparam int CW = $clog2(CREDITS + 1);
  localparam int BW = $clog2(talker_pkg::BYTES_PER_WORD);
  localparam logic [BW-1:0] LAST_BYTE = BW'(talker_pkg::BYTES_PER_WORD - 1);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_FETCH = 2'd1;
  localparam logic [1:0] ST_SEND = 2'd2;

  logic [1:0] state;
  logic [AW-1:0] cur_addr;
  logic [AW-1:0] end_addr;
  talker_pkg::flash_word_u word;
  logic [BW-1:0] byte_idx;
  logic [CW-1:0] credits;
  logic send;
  logic word_done;

  assign play.taken = (state == ST_IDLE) && play.valid;
  assign send = (state == ST_SEND) && (credits != '0);
  assign word_done = send && (byte_idx == LAST_BYTE);

  // ======================================================================
  // Playback FSM
  // ======================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state <= ST_IDLE;
      byte_idx <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          // Silent range is dropped right here
          if (play.valid && (play.end_word >= play.start_word))
            state <= ST_FETCH;
        ST_FETCH:
          if (bus.rvalid)
          begin
            state <= ST_SEND;
            byte_idx <= '0;
          end
        ST_SEND:
          if (send)
          begin
            byte_idx <= byte_idx + BW'(1);
            if (word_done)
              state <= (cur_addr == end_addr) ? ST_IDLE : ST_FETCH;
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Word pointer and the word being sent
  always_ff @(posedge CLK_50M)
  begin
    if (play.taken)
    begin
      cur_addr <= play.start_word;
      end_addr <= play.end_word;
    end
    else if (word_done)
      cur_addr <= cur_addr + AW'(1);
    if (bus.rvalid)
      word <= bus.rdata;
  end

  // Credits spent per sample, refunded by the sink
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      credits <= CW'(CREDITS);
    else if (send && !credit_return)
      credits <= credits - CW'(1);
    else if (!send && credit_return)
      credits <= credits + CW'(1);
  end

  assign bus.req = (state == ST_FETCH);
  assign bus.addr = cur_addr;

  assign sample_valid = send;
  assign sample_data = word.samples[byte_idx];
  assign playing = (state != ST_IDLE);

endmodule

/* rtl/phoneme_lookup.sv */
`timescale 1ns/100ps

module phoneme_lookup
(
  input  logic CLK_50M,
  input  logic rst,
  input  logic [talker_pkg::PHONEME_W-1:0] phoneme_code,
  input  logic phoneme_start,
  output logic phoneme_busy,
  flash_bus_if.requester bus,
  play_req_if.source play
);

  localparam int AW = talker_pkg::FLASH_ADDR_W;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_REQ = 2'd1;
  localparam logic [1:0] ST_FULL = 2'd2;

  logic [1:0] state;
  logic [AW-1:0] table_addr;
  logic accept;

  // Codes are ignored while busy
  assign accept = (state == ST_IDLE) && phoneme_start;

  // ======================================================================
  // Lookup FSM
  // ======================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      state <= ST_IDLE;
    else
    begin
      case (state)
        ST_IDLE:
          if (phoneme_start)
            state <= ST_REQ;
        ST_REQ:
          if (bus.rvalid)
            state <= ST_FULL;
        ST_FULL:
          if (play.taken)
            state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Table address and decoded range
  always_ff @(posedge CLK_50M)
  begin
    if (accept)
      table_addr <= talker_pkg::TABLE_BASE + AW'(phoneme_code);
    if (state == ST_REQ && bus.rvalid)
    begin
      play.start_word <= bus.rdata.entry[talker_pkg::ENTRY_START];
      play.end_word <= bus.rdata.entry[talker_pkg::ENTRY_END];
    end
  end

  assign bus.req = (state == ST_REQ);
  assign bus.addr = table_addr;

  // Slot stays full until the fetcher takes it
  assign play.valid = (state == ST_FULL);
  assign phoneme_busy = (state != ST_IDLE);

endmodule

/* rtl/flash_arbiter.sv */
`timescale 1ns/100ps

module flash_arbiter
(
  input  logic CLK_50M,
  input  logic rst,
  flash_bus_if.arbiter lookup_bus,
  flash_bus_if.arbiter fetch_bus,
  output logic flash_read,
  output logic [talker_pkg::FLASH_ADDR_W-1:0] flash_addr,
  input  logic flash_wait,
  input  logic [talker_pkg::FLASH_DATA_W-1:0] flash_rdata,
  input  logic flash_rdata_valid
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_READ = 2'd1;
  localparam logic [1:0] ST_WAIT = 2'd2;

  logic [1:0] state;
  // Owner of the current or last read, 0 lookup and 1 fetcher
  logic owner;
  logic pick;
  logic any_req;

  assign any_req = lookup_bus.req | fetch_bus.req;

  // Round robin, the side that did not own the last read wins a tie
  always_comb
  begin
    if (lookup_bus.req && fetch_bus.req)
      pick = ~owner;
    else
      pick = fetch_bus.req;
  end

  // ======================================================================
  // Read sequencing, one read outstanding at most
  // ======================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state <= ST_IDLE;
      owner <= 1'b1;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (any_req)
          begin
            owner <= pick;
            state <= ST_READ;
          end
        ST_READ:
          if (!flash_wait)
            state <= ST_WAIT;
        ST_WAIT:
          if (flash_rdata_valid)
            state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Address latched at grant, held through wait cycles
  always_ff @(posedge CLK_50M)
  begin
    if (state == ST_IDLE && any_req)
      flash_addr <= pick ? fetch_bus.addr : lookup_bus.addr;
  end

  assign flash_read = (state == ST_READ);

  // Word goes back to both, the pulse only to the owner
  assign lookup_bus.rdata = flash_rdata;
  assign fetch_bus.rdata = flash_rdata;
  assign lookup_bus.rvalid = (state == ST_WAIT) && flash_rdata_valid && !owner;
  assign fetch_bus.rvalid = (state == ST_WAIT) && flash_rdata_valid && owner;

endmodule

/* rtl/play_req_if.sv */
`timescale 1ns/100ps

interface play_req_if;

  // Range of sample words, stable while valid
  logic valid;
  logic [talker_pkg::FLASH_ADDR_W-1:0] start_word;
  logic [talker_pkg::FLASH_ADDR_W-1:0] end_word;

  // One-cycle accept from the fetcher
  logic taken;

  modport source
  (
    output valid,
    output start_word,
    output end_word,
    input  taken
  );

  modport sink
  (
    input  valid,
    input  start_word,
    input  end_word,
    output taken
  );

endinterface

/* rtl/flash_bus_if.sv */
`timescale 1ns/100ps

interface flash_bus_if;

  // Read request from one requester
  logic req;
  logic [talker_pkg::FLASH_ADDR_W-1:0] addr;

  // Returned word, rvalid pulses once per read
  talker_pkg::flash_word_u rdata;
  logic rvalid;

  // Requester holds req and addr until rvalid
  modport requester
  (
    output req,
    output addr,
    input  rdata,
    input  rvalid
  );

  modport arbiter
  (
    input  req,
    input  addr,
    output rdata,
    output rvalid
  );

endinterface

/* rtl/talker_pkg.sv */
package talker_pkg;

  // ======================================================================
  // Widths
  // ======================================================================

  // Flash is word addressed, one 32-bit word per address
  localparam int FLASH_ADDR_W = 16;
  localparam int FLASH_DATA_W = 32;

  localparam int SAMPLE_W = 8;
  localparam int BYTES_PER_WORD = FLASH_DATA_W / SAMPLE_W;

  // 64 phonemes in the table
  localparam int PHONEME_W = 6;

  // ======================================================================
  // Phoneme table layout
  // ======================================================================

  // Entry n sits at TABLE_BASE + n
  localparam logic [FLASH_ADDR_W-1:0] TABLE_BASE = '0;

  // Halves of a table entry
  localparam int ENTRY_START = 0;
  localparam int ENTRY_END = 1;

  // Sink credits after reset
  localparam int DEFAULT_CREDITS = 4;

  // One flash word, seen as samples or as a table entry.
  // Byte 0 of samples sits in the low bits and plays first.
  // Both bounds of an entry are inclusive; end below start means silence.
  typedef union packed
  {
    logic [BYTES_PER_WORD-1:0][SAMPLE_W-1:0] samples;
    logic [1:0][FLASH_ADDR_W-1:0] entry;
  } flash_word_u;

endpackage
